//--- compile.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipelineCore.sv
sim/clockGen.sv
sim/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run coreTb with Verilator, then look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module coreTb \
  -o coreTbSim > sim.log 2>&1 \
  && ./obj_dir/coreTbSim >> sim.log 2>&1 \
  || echo "build or simulation returned an error" >> sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim/coreTb.sv
`timescale 1ns/1ps
`include "coreSettings.svh"

module coreTb;
  import cpuPkg::*;

  localparam int programCount = 8;
  localparam int imemWords = 64;
  localparam int haltIdx = 39;
  localparam int haltTimeout = 2000;
  localparam int resetTimeout = 10;
  localparam int modelStepLimit = 1000;

  logic  CLK, nRST, resetReq;
  word_t imemAddr, imemData, dmemAddr, dmemStore, dmemLoad;
  logic  dmemRead, dmemWrite, halted;

  word_t imem [imemWords];
  word_t dutMem [`DMEM_WORDS];
  word_t modelMem [`DMEM_WORDS];
  word_t modelRegs [32];
  word_t expAddrQ [$];
  word_t expDataQ [$];
  word_t lcgState;
  word_t padWord;
  int    errors, checks, dutStores, modelStores;
  logic  timedOut;

  clockGen clk_i (.CLK(CLK), .nRST(nRST), .resetReq(resetReq));

  pipelineCore dut_i (
    .CLK(CLK), .nRST(nRST), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemRead(dmemRead), .dmemWrite(dmemWrite),
    .dmemStore(dmemStore), .dmemLoad(dmemLoad), .halted(halted)
  );

  function automatic word_t lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int randBelow(input int n);
    return int'((lcgNext() >> 8) % word_t'(n));
  endfunction

  // only r1..r7, so operands collide often
  function automatic regIdx_t randReg();
    return regIdx_t'(1 + randBelow(7));
  endfunction

  function automatic logic [15:0] randOffset();
    return 16'(4 * randBelow(`DMEM_WORDS));
  endfunction

  function automatic funct_t randFunct();
    case (randBelow(5))
      0: return ADDU;
      1: return SUBU;
      2: return AND;
      3: return OR;
      default: return SLT;
    endcase
  endfunction

  function automatic word_t encodeR(input funct_t f, input regIdx_t rd, input regIdx_t rs,
                                    input regIdx_t rt);
    instr_u w;
    w.r.opcode = RTYPE;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.shamt = '0;
    w.r.funct = f;
    return word_t'(w);
  endfunction

  function automatic word_t encodeI(input opcode_t op, input regIdx_t rs, input regIdx_t rt,
                                    input logic [15:0] imm);
    instr_u w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return word_t'(w);
  endfunction

  function automatic word_t fillWord(input int i);
    return {16'(i) ^ 16'hc3a5, 16'(i * 37 + 11)};
  endfunction

  function automatic void writeReg(input regIdx_t idx, input word_t value);
    if (idx != '0) begin
      modelRegs[idx] = value;
    end
  endfunction

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic checkStore(input word_t gotAddr, input word_t gotData,
                            input word_t expAddr, input word_t expData);
    checkWord("dmemAddr", gotAddr, expAddr);
    checkWord("dmemStore", gotData, expData);
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // constants first, then a random body, HALT and padding stores
  task automatic genProgram();
    int n;
    int kind;
    int reach;
    regIdx_t a, b, c;
    n = 0;
    for (int r = 1; r <= 7; r++) begin
      imem[n] = encodeI(LUI, '0, regIdx_t'(r), 16'(lcgNext()));
      imem[n + 1] = encodeI(ORI, regIdx_t'(r), regIdx_t'(r), 16'(lcgNext()));
      n += 2;
    end
    while (n < haltIdx) begin
      kind = randBelow(10);
      a = randReg();
      b = randReg();
      c = randReg();
      if (kind == 9 && n + 3 <= haltIdx) begin
        // load, dependent use at once, then a store of the result
        imem[n] = encodeI(LW, '0, a, randOffset());
        imem[n + 1] = encodeR(ADDU, b, a, c);
        imem[n + 2] = encodeI(SW, '0, b, randOffset());
        n += 3;
      end else begin
        case (kind)
          0, 1, 2: imem[n] = encodeR(randFunct(), a, b, c);
          3: imem[n] = encodeI(ADDIU, b, a, 16'(lcgNext()));
          4: imem[n] = encodeI(ORI, b, a, 16'(lcgNext()));
          5: imem[n] = encodeI(LW, '0, a, randOffset());
          6, 7: imem[n] = encodeI(SW, '0, a, randOffset());
          default: begin
            // forward only, never past HALT
            reach = (haltIdx - n < 4) ? haltIdx - n : 4;
            if (randBelow(2) == 0) begin
              c = b;
            end
            imem[n] = encodeI(randBelow(2) == 0 ? BEQ : BNE, b, c, 16'(randBelow(reach)));
          end
        endcase
        n++;
      end
    end
    imem[haltIdx] = encodeI(HALT, '0, '0, '0);
    for (int i = haltIdx + 1; i < imemWords; i++) begin
      imem[i] = padWord;
    end
  endtask

  task automatic initMemories();
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      dutMem[i] = fillWord(i);
      modelMem[i] = fillWord(i);
    end
  endtask

  // one instruction per step, in program order
  task automatic runModel();
    word_t  pc;
    instr_u w;
    word_t  rsVal, rtVal, sImm, zImm, addr;
    logic   done;
    int     steps;
    int     idx;
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = '0;
    end
    expAddrQ.delete();
    expDataQ.delete();
    modelStores = 0;
    pc = `RESET_PC;
    done = 1'b0;
    steps = 0;
    while (!done && steps < modelStepLimit) begin
      idx = int'(pc >> 2);
      w = instr_u'((idx < imemWords) ? imem[idx] : padWord);
      rsVal = modelRegs[w.i.rs];
      rtVal = modelRegs[w.i.rt];
      sImm = {{16{w.i.imm[15]}}, w.i.imm};
      zImm = {16'h0000, w.i.imm};
      addr = rsVal + sImm;
      pc = pc + 32'd4;
      case (w.i.opcode)
        RTYPE: begin
          case (w.r.funct)
            ADDU: writeReg(w.r.rd, rsVal + rtVal);
            SUBU: writeReg(w.r.rd, rsVal - rtVal);
            AND: writeReg(w.r.rd, rsVal & rtVal);
            OR: writeReg(w.r.rd, rsVal | rtVal);
            SLT: writeReg(w.r.rd, {31'b0, $signed(rsVal) < $signed(rtVal)});
            default: ;
          endcase
        end
        ADDIU: writeReg(w.i.rt, rsVal + sImm);
        ORI: writeReg(w.i.rt, rsVal | zImm);
        LUI: writeReg(w.i.rt, {w.i.imm, 16'h0000});
        LW: writeReg(w.i.rt, modelMem[int'((addr >> 2) % word_t'(`DMEM_WORDS))]);
        SW: begin
          modelMem[int'((addr >> 2) % word_t'(`DMEM_WORDS))] = rtVal;
          expAddrQ.push_back(addr);
          expDataQ.push_back(rtVal);
          modelStores++;
        end
        BEQ: if (rsVal == rtVal) pc = pc + (sImm << 2);
        BNE: if (rsVal != rtVal) pc = pc + (sImm << 2);
        HALT: done = 1'b1;
        default: ;
      endcase
      steps++;
    end
    if (!done) begin
      errors++;
      $display("model did not reach HALT within %0d steps", modelStepLimit);
    end
  endtask

  task automatic recordStore();
    word_t expAddr;
    word_t expData;
    dutStores++;
    if (dmemAddr[1:0] != 2'b00 || dmemAddr >= word_t'(`DMEM_WORDS * 4)) begin
      errors++;
      $display("store to 0x%08h falls outside the data memory", dmemAddr);
    end else begin
      dutMem[int'(dmemAddr >> 2)] = dmemStore;
    end
    if (expAddrQ.size() == 0) begin
      errors++;
      $display("store to 0x%08h was not expected by the model", dmemAddr);
    end else begin
      expAddr = expAddrQ.pop_front();
      expData = expDataQ.pop_front();
      checkStore(dmemAddr, dmemStore, expAddr, expData);
    end
  endtask

  // addresses are stable at the falling edge
  task automatic serveMemory();
    if (imemAddr < word_t'(imemWords * 4)) begin
      imemData = imem[int'(imemAddr >> 2)];
    end else begin
      imemData = padWord;
    end
    // load data only while the core reads
    if (dmemRead && dmemAddr < word_t'(`DMEM_WORDS * 4)) begin
      dmemLoad = dutMem[int'(dmemAddr >> 2)];
    end else begin
      dmemLoad = '0;
    end
    if (nRST && dmemWrite) begin
      recordStore();
    end
  endtask

  task automatic tick();
    @(negedge CLK);
    serveMemory();
  endtask

  task automatic applyReset();
    int cycles;
    resetReq <= 1'b1;
    cycles = 0;
    do begin
      tick();
      cycles++;
    end while (nRST !== 1'b0 && cycles < resetTimeout);
    if (nRST !== 1'b0) begin
      errors++;
      timedOut = 1'b1;
      $display("reset was not asserted within %0d cycles", resetTimeout);
      return;
    end
    resetReq <= 1'b0;
    checkFlag("halted", halted, 1'b0);
    checkFlag("dmemWrite", dmemWrite, 1'b0);
    checkFlag("dmemRead", dmemRead, 1'b0);
    checkWord("imemAddr", imemAddr, `RESET_PC);
    cycles = 0;
    while (nRST !== 1'b1 && cycles < resetTimeout) begin
      tick();
      cycles++;
    end
    if (nRST !== 1'b1) begin
      errors++;
      timedOut = 1'b1;
      $display("reset was not released within %0d cycles", resetTimeout);
    end
  endtask

  task automatic waitHalted();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < haltTimeout) begin
      tick();
      cycles++;
    end
    if (halted !== 1'b1) begin
      errors++;
      timedOut = 1'b1;
      $display("halted did not rise within %0d cycles", haltTimeout);
    end
  endtask

  // halted is sticky and nothing behind HALT may store
  task automatic checkResults();
    for (int k = 0; k < 8; k++) begin
      tick();
      checkFlag("halted", halted, 1'b1);
    end
    checkCount("store count", dutStores, modelStores);
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      checkWord($sformatf("dmem[%0d]", i), dutMem[i], modelMem[i]);
    end
  endtask

  initial begin
    int prog;
    int progErrors;
    errors = 0;
    checks = 0;
    timedOut = 1'b0;
    lcgState = 32'hb0e9;
    resetReq <= 1'b0;
    imemData = '0;
    dmemLoad = '0;
    padWord = encodeI(SW, '0, regIdx_t'(1), 16'h0000);
    for (prog = 0; prog < programCount && !timedOut; prog++) begin
      progErrors = errors;
      dutStores = 0;
      genProgram();
      initMemories();
      runModel();
      applyReset();
      if (!timedOut) begin
        waitHalted();
      end
      if (!timedOut) begin
        checkResults();
      end
      $display("program %0d: %0d stores, %0d errors", prog, dutStores, errors - progErrors);
    end
    $display("%0d programs, %0d checks, %0d errors", prog, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic CLK,
  output logic nRST,
  input  logic resetReq
);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // reset spans two rising edges and is released on a falling edge
  initial begin
    nRST <= 1'b0;
    forever begin
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      while (!resetReq) begin
        @(negedge CLK);
      end
      nRST <= 1'b0;
    end
  end

endmodule

//--- rtl/pipelineCore.sv
`timescale 1ns/1ps

module pipelineCore (
  input  logic          CLK,
  input  logic          nRST,
  output cpuPkg::word_t imemAddr,
  input  cpuPkg::word_t imemData,
  output cpuPkg::word_t dmemAddr,
  output logic          dmemRead,
  output logic          dmemWrite,
  output cpuPkg::word_t dmemStore,
  input  cpuPkg::word_t dmemLoad,
  output logic          halted
);
  import cpuPkg::*;

  // fetch/decode
  word_t   instrD, pcPlus4D;
  logic    validD, stall;
  logic    redirect;
  word_t   redirectPc;
  // register file
  regIdx_t readIdxA, readIdxB;
  word_t   readDataA, readDataB;
  // decode/execute
  aluOp_t  aluOpE;
  logic    useImmE, signExtE, isLuiE;
  logic    regWriteE, memReadE, memWriteE;
  logic    isBranchE, branchOnNeE, haltE;
  word_t   operandAE, operandBE, pcPlus4E;
  logic [15:0] immE;
  regIdx_t rsE, rtE, destE;
  // execute/memory
  word_t   aluResultM, storeDataM;
  regIdx_t destM;
  logic    regWriteM, memReadM, memWriteM, haltM;
  // write-back
  word_t   wbData;
  regIdx_t wbDest;
  logic    wbWrite;

  fetchStage fetch_i (
    .CLK(CLK), .nRST(nRST), .stall(stall), .redirect(redirect),
    .redirectPc(redirectPc), .imemAddr(imemAddr), .imemData(imemData),
    .instrD(instrD), .pcPlus4D(pcPlus4D), .validD(validD)
  );

  registerFile regFile_i (
    .CLK(CLK), .nRST(nRST), .readIdxA(readIdxA), .readIdxB(readIdxB),
    .readDataA(readDataA), .readDataB(readDataB), .writeEn(wbWrite),
    .writeIdx(wbDest), .writeData(wbData)
  );

  decodeStage decode_i (
    .CLK(CLK), .nRST(nRST), .instrD(instrD), .pcPlus4D(pcPlus4D), .validD(validD),
    .redirect(redirect), .readIdxA(readIdxA), .readIdxB(readIdxB),
    .readDataA(readDataA), .readDataB(readDataB), .stall(stall),
    .aluOpE(aluOpE), .useImmE(useImmE), .signExtE(signExtE), .isLuiE(isLuiE),
    .regWriteE(regWriteE), .memReadE(memReadE), .memWriteE(memWriteE),
    .isBranchE(isBranchE), .branchOnNeE(branchOnNeE), .haltE(haltE),
    .operandAE(operandAE), .operandBE(operandBE), .immE(immE),
    .rsE(rsE), .rtE(rtE), .destE(destE), .pcPlus4E(pcPlus4E)
  );

  executeStage execute_i (
    .CLK(CLK), .nRST(nRST), .aluOpE(aluOpE), .useImmE(useImmE),
    .signExtE(signExtE), .isLuiE(isLuiE), .regWriteE(regWriteE),
    .memReadE(memReadE), .memWriteE(memWriteE), .isBranchE(isBranchE),
    .branchOnNeE(branchOnNeE), .haltE(haltE), .operandAE(operandAE),
    .operandBE(operandBE), .immE(immE), .rsE(rsE), .rtE(rtE), .destE(destE),
    .pcPlus4E(pcPlus4E), .wbData(wbData), .wbDest(wbDest), .wbWrite(wbWrite),
    .aluResultM(aluResultM), .storeDataM(storeDataM), .destM(destM),
    .regWriteM(regWriteM), .memReadM(memReadM), .memWriteM(memWriteM),
    .haltM(haltM), .redirect(redirect), .redirectPc(redirectPc)
  );

  memoryStage memory_i (
    .CLK(CLK), .nRST(nRST), .aluResultM(aluResultM), .storeDataM(storeDataM),
    .destM(destM), .regWriteM(regWriteM), .memReadM(memReadM),
    .memWriteM(memWriteM), .haltM(haltM), .dmemAddr(dmemAddr),
    .dmemRead(dmemRead), .dmemWrite(dmemWrite), .dmemStore(dmemStore),
    .dmemLoad(dmemLoad), .wbData(wbData), .wbDest(wbDest), .wbWrite(wbWrite),
    .halted(halted)
  );

endmodule

//--- rtl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::word_t   aluResultM,
  input  cpuPkg::word_t   storeDataM,
  input  cpuPkg::regIdx_t destM,
  input  logic            regWriteM,
  input  logic            memReadM,
  input  logic            memWriteM,
  input  logic            haltM,
  output cpuPkg::word_t   dmemAddr,
  output logic            dmemRead,
  output logic            dmemWrite,
  output cpuPkg::word_t   dmemStore,
  input  cpuPkg::word_t   dmemLoad,
  output cpuPkg::word_t   wbData,
  output cpuPkg::regIdx_t wbDest,
  output logic            wbWrite,
  output logic            halted
);
  import cpuPkg::*;

  word_t  resultW;
  word_t  loadW;
  wbSel_t wbSelW;
  logic   haltW;

  // memory answers within the cycle
  assign dmemAddr = aluResultM;
  assign dmemRead = memReadM;
  assign dmemWrite = memWriteM;
  assign dmemStore = storeDataM;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resultW <= '0;
      loadW <= '0;
      wbSelW <= WB_ALU;
      wbDest <= '0;
      wbWrite <= 1'b0;
      haltW <= 1'b0;
    end else begin
      resultW <= aluResultM;
      loadW <= dmemLoad;
      wbSelW <= memReadM ? WB_MEM : WB_ALU;
      wbDest <= destM;
      wbWrite <= regWriteM;
      haltW <= haltM;
    end
  end

  assign wbData = (wbSelW == WB_MEM) ? loadW : resultW;

  // sticky once HALT has retired
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halted <= 1'b0;
    end else if (haltW) begin
      halted <= 1'b1;
    end
  end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/1ps
`include "coreSettings.svh"

module executeStage (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::aluOp_t  aluOpE,
  input  logic            useImmE,
  input  logic            signExtE,
  input  logic            isLuiE,
  input  logic            regWriteE,
  input  logic            memReadE,
  input  logic            memWriteE,
  input  logic            isBranchE,
  input  logic            branchOnNeE,
  input  logic            haltE,
  input  cpuPkg::word_t   operandAE,
  input  cpuPkg::word_t   operandBE,
  input  logic [15:0]     immE,
  input  cpuPkg::regIdx_t rsE,
  input  cpuPkg::regIdx_t rtE,
  input  cpuPkg::regIdx_t destE,
  input  cpuPkg::word_t   pcPlus4E,
  input  cpuPkg::word_t   wbData,
  input  cpuPkg::regIdx_t wbDest,
  input  logic            wbWrite,
  output cpuPkg::word_t   aluResultM,
  output cpuPkg::word_t   storeDataM,
  output cpuPkg::regIdx_t destM,
  output logic            regWriteM,
  output logic            memReadM,
  output logic            memWriteM,
  output logic            haltM,
  output logic            redirect,
  output cpuPkg::word_t   redirectPc
);
  import cpuPkg::*;

  word_t fwdA;
  word_t fwdB;
  word_t immExt;
  word_t srcB;
  word_t aluResult;
  logic  operandsEqual;

  // memory stage first, then write-back, then the register value
  function automatic word_t forward(input regIdx_t idx, input word_t regValue);
    if (regWriteM && !memReadM && destM != '0 && destM == idx) begin
      return aluResultM;
    end
    if (wbWrite && wbDest != '0 && wbDest == idx) begin
      return wbData;
    end
    return regValue;
  endfunction

  always_comb begin
    fwdA = forward(rsE, operandAE);
    fwdB = forward(rtE, operandBE);
  end

  always_comb begin
    if (isLuiE) begin
      immExt = {immE, 16'h0000};
    end else if (signExtE) begin
      immExt = {{(`WORD_W-16){immE[15]}}, immE};
    end else begin
      immExt = {{(`WORD_W-16){1'b0}}, immE};
    end
  end

  assign srcB = useImmE ? immExt : fwdB;

  always_comb begin
    case (aluOpE)
      ALU_ADD: aluResult = fwdA + srcB;
      ALU_SUB: aluResult = fwdA - srcB;
      ALU_AND: aluResult = fwdA & srcB;
      ALU_OR: aluResult = fwdA | srcB;
      ALU_SLT: aluResult = word_t'($signed(fwdA) < $signed(srcB));
      default: aluResult = srcB;
    endcase
  end

  // branches compare the forwarded register pair
  assign operandsEqual = fwdA == fwdB;
  assign redirect = isBranchE && (branchOnNeE ? !operandsEqual : operandsEqual);
  assign redirectPc = pcPlus4E + {{(`WORD_W-18){immE[15]}}, immE, 2'b00};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      aluResultM <= '0;
      storeDataM <= '0;
      destM <= '0;
      regWriteM <= 1'b0;
      memReadM <= 1'b0;
      memWriteM <= 1'b0;
      haltM <= 1'b0;
    end else begin
      aluResultM <= aluResult;
      storeDataM <= fwdB;
      destM <= destE;
      regWriteM <= regWriteE;
      memReadM <= memReadE;
      memWriteM <= memWriteE;
      haltM <= haltE;
    end
  end

endmodule

//--- rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::word_t   instrD,
  input  cpuPkg::word_t   pcPlus4D,
  input  logic            validD,
  input  logic            redirect,
  output cpuPkg::regIdx_t readIdxA,
  output cpuPkg::regIdx_t readIdxB,
  input  cpuPkg::word_t   readDataA,
  input  cpuPkg::word_t   readDataB,
  output logic            stall,
  output cpuPkg::aluOp_t  aluOpE,
  output logic            useImmE,
  output logic            signExtE,
  output logic            isLuiE,
  output logic            regWriteE,
  output logic            memReadE,
  output logic            memWriteE,
  output logic            isBranchE,
  output logic            branchOnNeE,
  output logic            haltE,
  output cpuPkg::word_t   operandAE,
  output cpuPkg::word_t   operandBE,
  output logic [15:0]     immE,
  output cpuPkg::regIdx_t rsE,
  output cpuPkg::regIdx_t rtE,
  output cpuPkg::regIdx_t destE,
  output cpuPkg::word_t   pcPlus4E
);
  import cpuPkg::*;

  instr_u  instr;
  aluOp_t  aluOp;
  regIdx_t dest;
  logic    useImm, signExt, isLui;
  logic    regWrite, memRead, memWrite;
  logic    isBranch, branchOnNe, isHalt;
  logic    usesRs, usesRt;
  logic    haltSeen;
  logic    live;
  logic    issue;

  assign instr = instr_u'(instrD);
  assign readIdxA = instr.r.rs;
  assign readIdxB = instr.i.rt;

  always_comb begin
    aluOp = ALU_ADD;
    dest = instr.i.rt;
    useImm = 1'b0;
    signExt = 1'b0;
    isLui = 1'b0;
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    isBranch = 1'b0;
    branchOnNe = 1'b0;
    isHalt = 1'b0;
    usesRs = 1'b0;
    usesRt = 1'b0;
    case (instr.i.opcode)
      RTYPE: begin
        dest = instr.r.rd;
        usesRs = 1'b1;
        usesRt = 1'b1;
        regWrite = 1'b1;
        case (instr.r.funct)
          ADDU: aluOp = ALU_ADD;
          SUBU: aluOp = ALU_SUB;
          AND: aluOp = ALU_AND;
          OR: aluOp = ALU_OR;
          SLT: aluOp = ALU_SLT;
          // unknown funct retires as a no-op
          default: regWrite = 1'b0;
        endcase
      end
      ADDIU, LW, SW: begin
        useImm = 1'b1;
        signExt = 1'b1;
        usesRs = 1'b1;
        usesRt = instr.i.opcode == SW;
        regWrite = instr.i.opcode != SW;
        memRead = instr.i.opcode == LW;
        memWrite = instr.i.opcode == SW;
      end
      ORI: begin
        aluOp = ALU_OR;
        useImm = 1'b1;
        usesRs = 1'b1;
        regWrite = 1'b1;
      end
      LUI: begin
        aluOp = ALU_LUI;
        useImm = 1'b1;
        isLui = 1'b1;
        regWrite = 1'b1;
      end
      BEQ, BNE: begin
        signExt = 1'b1;
        isBranch = 1'b1;
        branchOnNe = instr.i.opcode == BNE;
        usesRs = 1'b1;
        usesRt = 1'b1;
      end
      HALT: isHalt = 1'b1;
      default: ;
    endcase
  end

  // nothing issues once a HALT has gone by
  assign live = validD && !haltSeen;

  // load in execute feeding an operand used here
  assign stall = live && memReadE && destE != '0 &&
                 ((usesRs && instr.r.rs == destE) || (usesRt && instr.i.rt == destE));

  assign issue = live && !stall && !redirect;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      haltSeen <= 1'b0;
    end else if (issue && isHalt) begin
      haltSeen <= 1'b1;
    end
  end

  // decode/execute register, control cleared for bubbles
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      aluOpE <= ALU_ADD;
      useImmE <= 1'b0;
      signExtE <= 1'b0;
      isLuiE <= 1'b0;
      regWriteE <= 1'b0;
      memReadE <= 1'b0;
      memWriteE <= 1'b0;
      isBranchE <= 1'b0;
      branchOnNeE <= 1'b0;
      haltE <= 1'b0;
      operandAE <= '0;
      operandBE <= '0;
      immE <= '0;
      rsE <= '0;
      rtE <= '0;
      destE <= '0;
      pcPlus4E <= '0;
    end else begin
      aluOpE <= aluOp;
      useImmE <= useImm;
      signExtE <= signExt;
      isLuiE <= isLui;
      regWriteE <= issue && regWrite;
      memReadE <= issue && memRead;
      memWriteE <= issue && memWrite;
      isBranchE <= issue && isBranch;
      branchOnNeE <= branchOnNe;
      haltE <= issue && isHalt;
      operandAE <= readDataA;
      operandBE <= readDataB;
      immE <= instr.i.imm;
      rsE <= instr.r.rs;
      rtE <= instr.i.rt;
      destE <= dest;
      pcPlus4E <= pcPlus4D;
    end
  end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input  logic            CLK,
  input  logic            nRST,
  input  cpuPkg::regIdx_t readIdxA,
  input  cpuPkg::regIdx_t readIdxB,
  output cpuPkg::word_t   readDataA,
  output cpuPkg::word_t   readDataB,
  input  logic            writeEn,
  input  cpuPkg::regIdx_t writeIdx,
  input  cpuPkg::word_t   writeData
);
  import cpuPkg::*;

  localparam int regCount = 2 ** $bits(regIdx_t);

  // entry zero is never written
  word_t regs [regCount];

  function automatic word_t readPort(input regIdx_t idx);
    if (idx == '0) begin
      return '0;
    end
    // write-back in flight this cycle
    if (writeEn && writeIdx == idx) begin
      return writeData;
    end
    return regs[idx];
  endfunction

  always_comb begin
    readDataA = readPort(readIdxA);
    readDataB = readPort(readIdxB);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && writeIdx != '0) begin
      regs[writeIdx] <= writeData;
    end
  end

endmodule

//--- rtl/fetchStage.sv
`timescale 1ns/1ps
`include "coreSettings.svh"

module fetchStage (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          stall,
  input  logic          redirect,
  input  cpuPkg::word_t redirectPc,
  output cpuPkg::word_t imemAddr,
  input  cpuPkg::word_t imemData,
  output cpuPkg::word_t instrD,
  output cpuPkg::word_t pcPlus4D,
  output logic          validD
);
  import cpuPkg::*;

  word_t pc;
  word_t pcPlus4;

  assign imemAddr = pc;
  assign pcPlus4 = pc + word_t'(4);

  // redirect wins over a load-use hold
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall) begin
      pc <= pcPlus4;
    end
  end

  // fetch/decode register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      instrD <= '0;
      pcPlus4D <= '0;
      validD <= 1'b0;
    end else if (redirect) begin
      // wrong-path word becomes a bubble
      validD <= 1'b0;
    end else if (!stall) begin
      instrD <= imemData;
      pcPlus4D <= pcPlus4;
      validD <= 1'b1;
    end
  end

endmodule

//--- rtl/cpuPkg.sv
`include "coreSettings.svh"

package cpuPkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_IDX_W-1:0] regIdx_t;

  // primary opcodes, MIPS encodings except HALT
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    // passes operand B, which holds the shifted LUI immediate
    ALU_LUI
  } aluOp_t;

  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wbSel_t;

  typedef struct packed {
    opcode_t     opcode;
    regIdx_t     rs;
    regIdx_t     rt;
    regIdx_t     rd;
    logic [4:0]  shamt;
    funct_t      funct;
  } rType_t;

  typedef struct packed {
    opcode_t     opcode;
    regIdx_t     rs;
    regIdx_t     rt;
    logic [15:0] imm;
  } iType_t;

  // one instruction word, two field layouts
  typedef union packed {
    rType_t r;
    iType_t i;
  } instr_u;

endpackage

//--- rtl/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and address width
`define WORD_W 32
// register index width, 32 registers
`define REG_IDX_W 5
// first fetch address out of reset
`define RESET_PC 32'h0000_0000
// data memory depth in words
`define DMEM_WORDS 64

`endif
